// ==== design/egress_qs_pkg.sv ====
/*
 * Egress queue package
 * Sizes, vector types and the reader FSM encoding shared by the
 * two-port egress packet queue
 */
package egress_qs_pkg;

    // --------------------------------------------------
    // Sizes
    // --------------------------------------------------
    localparam int NUM_PORTS    = 2;
    localparam int SLOT_WORDS   = 16;
    localparam int NUM_SLOTS    = 8;
    localparam int DATA_WID     = 32;

    localparam int PORT_WID     = $clog2(NUM_PORTS);
    localparam int SLOT_WID     = $clog2(NUM_SLOTS);
    localparam int WORD_WID     = $clog2(SLOT_WORDS);
    localparam int BANK_AW      = SLOT_WID + WORD_WID;
    localparam int BANK_WORDS   = NUM_SLOTS * SLOT_WORDS;
    // Port, slot and word offset from MSB down
    localparam int MEM_ADDR_WID = PORT_WID + BANK_AW;

    // --------------------------------------------------
    // Types
    // --------------------------------------------------
    typedef logic [DATA_WID-1:0]     data_t;
    typedef logic [MEM_ADDR_WID-1:0] mem_addr_t;
    typedef logic [SLOT_WID-1:0]     slot_t;
    typedef logic [WORD_WID:0]       wcount_t;
    typedef logic [PORT_WID-1:0]     port_t;

    typedef enum logic {RD_IDLE, RD_BUSY} rd_state_t;

    // Base of each port's bank in the buffer address space
    localparam mem_addr_t PORT_BASE [NUM_PORTS] = '{8'h00, 8'h80};

endpackage

// ==== design/buf_rd_if.sv ====
/*
 * Buffer read request interface
 * Carries one reader's requests to the shared read port arbiter and
 * the returned data, one cycle after each grant
 */
`timescale 1ns/1ns

interface buf_rd_if
    import egress_qs_pkg::*;
();

    logic      req;
    logic      gnt;
    mem_addr_t addr;
    logic      rvalid;
    data_t     rdata;

    // Reader side, req and addr held until gnt
    modport requester (
        output req, addr,
        input  gnt, rvalid, rdata
    );

    modport arbiter (
        input  req, addr,
        output gnt, rvalid, rdata
    );

endinterface

// ==== design/buf_mem.sv ====
/*
 * Packet buffer memory
 * One bank per port, each written from its own port, with a single
 * shared registered read port
 */
`timescale 1ns/1ns

module buf_mem
    import egress_qs_pkg::*;
(
    input  logic      clk,
    input  logic      i_wr_en   [NUM_PORTS],
    input  mem_addr_t i_wr_addr [NUM_PORTS],
    input  data_t     i_wr_data [NUM_PORTS],
    input  mem_addr_t i_rd_addr,
    output data_t     o_rd_data
);

    data_t mem [NUM_PORTS][BANK_WORDS];

    always_ff @(posedge clk) begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (i_wr_en[p]) begin
                mem[p][i_wr_addr[p][BANK_AW-1:0]] <= i_wr_data[p];
            end
        end
        // Port bits select the bank
        o_rd_data <= mem[i_rd_addr[MEM_ADDR_WID-1 -: PORT_WID]][i_rd_addr[BANK_AW-1:0]];
    end

endmodule

// ==== design/buf_rd_arbiter.sv ====
/*
 * Buffer read arbiter
 * Round-robin grant of the shared memory read port, one reader per
 * cycle, with the read data routed back to the winner
 */
`timescale 1ns/1ns

module buf_rd_arbiter
    import egress_qs_pkg::*;
(
    input  logic      clk,
    input  logic      i_rst_n,
    buf_rd_if.arbiter rd [NUM_PORTS],
    output mem_addr_t o_mem_addr,
    input  data_t     i_mem_data
);

    logic [NUM_PORTS-1:0] req_vec;
    logic [NUM_PORTS-1:0] gnt_vec;
    mem_addr_t            addr_vec [NUM_PORTS];
    port_t                prio;
    port_t                win;
    port_t                last_win;
    logic                 any_req;
    logic                 rvalid_q;

    // --------------------------------------------------
    // Interface fan-in and fan-out
    // --------------------------------------------------
    for (genvar g = 0; g < NUM_PORTS; g++) begin : g_rd
        assign req_vec[g]   = rd[g].req;
        assign addr_vec[g]  = rd[g].addr;
        assign rd[g].gnt    = gnt_vec[g];
        // Only the port granted last cycle sees rvalid
        assign rd[g].rvalid = rvalid_q && (last_win == port_t'(g));
        assign rd[g].rdata  = i_mem_data;
    end

    // --------------------------------------------------
    // Round-robin pick
    // --------------------------------------------------
    always_comb begin
        port_t cand;
        win     = prio;
        any_req = 1'b0;
        // Walk down so the port at prio is checked last and wins
        for (int k = NUM_PORTS - 1; k >= 0; k--) begin
            cand = prio + port_t'(k);
            if (req_vec[cand]) begin
                win     = cand;
                any_req = 1'b1;
            end
        end
        gnt_vec = '0;
        if (any_req) begin
            gnt_vec[win] = 1'b1;
        end
    end

    assign o_mem_addr = addr_vec[win];

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            prio     <= '0;
            last_win <= '0;
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= any_req;
            if (any_req) begin
                last_win <= win;
                prio     <= win + 1'b1;
            end
        end
    end

endmodule

// ==== design/pkt_writer.sv ====
/*
 * Packet writer
 * Stores incoming words into the port's next free slot, drops packets
 * that find no slot or overrun one, and pushes a descriptor per packet
 */
`timescale 1ns/1ns

module pkt_writer
    import egress_qs_pkg::*;
#(
    parameter port_t PORT_IDX = '0
) (
    input  logic      clk,
    input  logic      i_rst_n,
    input  logic      i_valid,
    input  logic      i_last,
    input  data_t     i_data,
    input  logic      i_slot_free,
    output logic      o_wr_en,
    output mem_addr_t o_wr_addr,
    output data_t     o_wr_data,
    output logic      o_push,
    output slot_t     o_push_slot,
    output wcount_t   o_push_count,
    output logic      o_drop_evt
);

    logic              in_pkt;
    logic              dropping;
    wcount_t           cnt;
    slot_t             wr_slot;
    logic [SLOT_WID:0] in_use;
    logic              start;
    logic              drop_now;
    logic              take;
    logic              commit;

    assign start    = i_valid && !in_pkt;
    // No free slot at the first word, or a word beyond a full slot
    assign drop_now = (start && (in_use == NUM_SLOTS)) ||
                      (i_valid && in_pkt && !dropping && (cnt == SLOT_WORDS));
    assign take     = i_valid && !drop_now && !(in_pkt && dropping);
    assign commit   = take && i_last;

    assign o_wr_en   = take;
    assign o_wr_addr = PORT_BASE[PORT_IDX] | mem_addr_t'({wr_slot, cnt[WORD_WID-1:0]});
    assign o_wr_data = i_data;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            in_pkt     <= 1'b0;
            dropping   <= 1'b0;
            cnt        <= '0;
            wr_slot    <= '0;
            in_use     <= '0;
            o_push     <= 1'b0;
            o_drop_evt <= 1'b0;
        end else begin
            o_push     <= commit;
            o_drop_evt <= drop_now;
            if (i_valid) begin
                in_pkt <= !i_last;
                if (i_last) begin
                    cnt      <= '0;
                    dropping <= 1'b0;
                end else begin
                    if (drop_now) dropping <= 1'b1;
                    if (take)     cnt      <= cnt + 1'b1;
                end
            end
            if (commit) wr_slot <= wr_slot + 1'b1;
            // Slot count, taken at commit and returned by the reader
            case ({commit, i_slot_free})
                2'b10:   in_use <= in_use + 1'b1;
                2'b01:   in_use <= in_use - 1'b1;
                default: ;
            endcase
        end
    end

    // Descriptor for the packet just completed
    always_ff @(posedge clk) begin
        if (commit) begin
            o_push_slot  <= wr_slot;
            o_push_count <= cnt + 1'b1;
        end
    end

endmodule

// ==== design/desc_fifo.sv ====
/*
 * Descriptor FIFO
 * First-word-fall-through queue of slot and word count, one entry per
 * slot, standing in for the scheduler
 */
`timescale 1ns/1ns

module desc_fifo
    import egress_qs_pkg::*;
(
    input  logic    clk,
    input  logic    i_rst_n,
    input  logic    i_push,
    input  slot_t   i_slot,
    input  wcount_t i_count,
    input  logic    i_pop,
    output logic    o_empty,
    output slot_t   o_slot,
    output wcount_t o_count
);

    slot_t             slot_mem [NUM_SLOTS];
    wcount_t           cnt_mem  [NUM_SLOTS];
    slot_t             wr_ptr;
    slot_t             rd_ptr;
    logic [SLOT_WID:0] level;

    assign o_empty = (level == '0);
    // Head entry shows without a pop
    assign o_slot  = slot_mem[rd_ptr];
    assign o_count = cnt_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (i_push) begin
            slot_mem[wr_ptr] <= i_slot;
            cnt_mem[wr_ptr]  <= i_count;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (i_push) wr_ptr <= wr_ptr + 1'b1;
            if (i_pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({i_push, i_pop})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: ;
            endcase
        end
    end

endmodule

// ==== design/pkt_reader.sv ====
/*
 * Packet reader
 * Pops a descriptor, reads its words from the buffer through the
 * arbiter and drives them out with valid/ready and a last flag
 */
`timescale 1ns/1ns

module pkt_reader
    import egress_qs_pkg::*;
#(
    parameter port_t PORT_IDX = '0
) (
    input  logic        clk,
    input  logic        i_rst_n,
    input  logic        i_empty,
    input  slot_t       i_slot,
    input  wcount_t     i_count,
    output logic        o_pop,
    buf_rd_if.requester rd,
    output logic        o_slot_free,
    output logic        o_valid,
    output logic        o_last,
    output data_t       o_data,
    input  logic        i_ready
);

    rd_state_t state;
    slot_t     slot_q;
    wcount_t   cnt_q;
    wcount_t   req_idx;
    logic      last_req;
    logic      inflight;
    logic      inflight_last;
    logic      load_out;
    logic      sk_valid;
    logic      sk_last;
    data_t     sk_data;

    assign last_req = (req_idx + 1'b1 == cnt_q);
    assign load_out = !o_valid || i_ready;

    assign o_pop = (state == RD_IDLE) && !i_empty;
    // No request under back-pressure or while a word is still pending
    assign rd.req  = (state == RD_BUSY) && load_out && !(o_valid && (sk_valid || inflight));
    assign rd.addr = PORT_BASE[PORT_IDX] | mem_addr_t'({slot_q, req_idx[WORD_WID-1:0]});
    assign o_slot_free = rd.rvalid && inflight_last;

    // --------------------------------------------------
    // Request FSM and word flow control
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state         <= RD_IDLE;
            req_idx       <= '0;
            inflight      <= 1'b0;
            inflight_last <= 1'b0;
            o_valid       <= 1'b0;
            sk_valid      <= 1'b0;
        end else begin
            inflight      <= rd.gnt;
            inflight_last <= rd.gnt && last_req;
            case (state)
                RD_IDLE: begin
                    if (o_pop) begin
                        state   <= RD_BUSY;
                        req_idx <= '0;
                    end
                end
                RD_BUSY: begin
                    if (rd.gnt) begin
                        req_idx <= req_idx + 1'b1;
                        if (last_req) state <= RD_IDLE;
                    end
                end
                default: state <= RD_IDLE;
            endcase
            if (load_out) begin
                o_valid  <= sk_valid || rd.rvalid;
                sk_valid <= sk_valid && rd.rvalid;
            end else if (rd.rvalid) begin
                sk_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (o_pop) begin
            slot_q <= i_slot;
            cnt_q  <= i_count;
        end
        if (load_out) begin
            o_data <= sk_valid ? sk_data : rd.rdata;
            o_last <= sk_valid ? sk_last : inflight_last;
        end
        // Skid entry catches a word that cannot enter the output register
        if (rd.rvalid && (sk_valid || !load_out)) begin
            sk_data <= rd.rdata;
            sk_last <= inflight_last;
        end
    end

endmodule

// ==== design/egress_port.sv ====
/*
 * Egress port
 * Writer, descriptor FIFO and reader for one port, plus the one-stage
 * bypass path and the sticky drop flag
 */
`timescale 1ns/1ns

module egress_port
    import egress_qs_pkg::*;
#(
    parameter port_t PORT_IDX = '0
) (
    input  logic        clk,
    input  logic        i_rst_n,
    input  logic        i_enable,
    input  logic        i_in_valid,
    input  logic        i_in_last,
    input  data_t       i_in_data,
    output logic        o_wr_en,
    output mem_addr_t   o_wr_addr,
    output data_t       o_wr_data,
    buf_rd_if.requester rd,
    output logic        o_out_valid,
    output logic        o_out_last,
    output data_t       o_out_data,
    input  logic        i_out_ready,
    input  logic        i_status_clear,
    output logic        o_drop
);

    logic    push, pop, empty, slot_free, drop_evt;
    slot_t   push_slot, head_slot;
    wcount_t push_count, head_count;
    logic    q_valid, q_last;
    data_t   q_data;
    logic    byp_valid, byp_last;
    data_t   byp_data;

    pkt_writer #(.PORT_IDX(PORT_IDX)) u_writer (
        .clk, .i_rst_n,
        .i_valid (i_in_valid && i_enable), .i_last (i_in_last), .i_data (i_in_data),
        .i_slot_free (slot_free),
        .o_wr_en, .o_wr_addr, .o_wr_data,
        .o_push (push), .o_push_slot (push_slot), .o_push_count (push_count),
        .o_drop_evt (drop_evt)
    );

    desc_fifo u_fifo (
        .clk, .i_rst_n,
        .i_push (push), .i_slot (push_slot), .i_count (push_count),
        .i_pop (pop), .o_empty (empty), .o_slot (head_slot), .o_count (head_count)
    );

    pkt_reader #(.PORT_IDX(PORT_IDX)) u_reader (
        .clk, .i_rst_n,
        .i_empty (empty), .i_slot (head_slot), .i_count (head_count), .o_pop (pop),
        .rd, .o_slot_free (slot_free),
        .o_valid (q_valid), .o_last (q_last), .o_data (q_data), .i_ready (i_out_ready)
    );

    // --------------------------------------------------
    // Bypass stage and drop status
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            byp_valid <= 1'b0;
            o_drop    <= 1'b0;
        end else begin
            byp_valid <= i_in_valid;
            // Clear has priority over a new drop
            if (i_status_clear) o_drop <= 1'b0;
            else if (drop_evt)  o_drop <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        byp_last <= i_in_last;
        byp_data <= i_in_data;
    end

    assign o_out_valid = i_enable ? q_valid : byp_valid;
    assign o_out_last  = i_enable ? q_last  : byp_last;
    assign o_out_data  = i_enable ? q_data  : byp_data;

endmodule

// ==== design/egress_qs.sv ====
/*
 * Two-port egress packet queue
 * Each port queues packets in its own buffer bank and sends them back
 * out on the same port, sharing one memory read port
 */
`timescale 1ns/1ns

module egress_qs
    import egress_qs_pkg::*;
(
    input  logic                  clk,
    input  logic                  i_rst_n,
    input  logic                  i_enable,
    input  logic [NUM_PORTS-1:0]  i_in_valid,
    input  logic [NUM_PORTS-1:0]  i_in_last,
    input  data_t [NUM_PORTS-1:0] i_in_data,
    output logic [NUM_PORTS-1:0]  o_out_valid,
    output logic [NUM_PORTS-1:0]  o_out_last,
    output data_t [NUM_PORTS-1:0] o_out_data,
    input  logic [NUM_PORTS-1:0]  i_out_ready,
    input  logic                  i_status_clear,
    output logic [NUM_PORTS-1:0]  o_drop
);

    logic      wr_en   [NUM_PORTS];
    mem_addr_t wr_addr [NUM_PORTS];
    data_t     wr_data [NUM_PORTS];
    mem_addr_t mem_rd_addr;
    data_t     mem_rd_data;

    buf_rd_if rd_if [NUM_PORTS] ();

    // --------------------------------------------------
    // Per-port queues
    // --------------------------------------------------
    for (genvar g = 0; g < NUM_PORTS; g++) begin : g_port
        egress_port #(.PORT_IDX(port_t'(g))) u_port (
            .clk, .i_rst_n, .i_enable,
            .i_in_valid (i_in_valid[g]), .i_in_last (i_in_last[g]), .i_in_data (i_in_data[g]),
            .o_wr_en (wr_en[g]), .o_wr_addr (wr_addr[g]), .o_wr_data (wr_data[g]),
            .rd (rd_if[g]),
            .o_out_valid (o_out_valid[g]), .o_out_last (o_out_last[g]),
            .o_out_data (o_out_data[g]), .i_out_ready (i_out_ready[g]),
            .i_status_clear, .o_drop (o_drop[g])
        );
    end

    // Writers own their banks, only reads are shared
    buf_rd_arbiter u_arbiter (
        .clk, .i_rst_n,
        .rd (rd_if),
        .o_mem_addr (mem_rd_addr),
        .i_mem_data (mem_rd_data)
    );

    buf_mem u_mem (
        .clk,
        .i_wr_en (wr_en), .i_wr_addr (wr_addr), .i_wr_data (wr_data),
        .i_rd_addr (mem_rd_addr),
        .o_rd_data (mem_rd_data)
    );

endmodule

// ==== tests/tb_egress_qs.sv ====
/*
 * Egress queue testbench
 * Directed tests for queue order, both ports, back-pressure, drops
 * and bypass, checked against per-port queues of expected words
 */
`timescale 1ns/1ns

module tb_egress_qs
    import egress_qs_pkg::*;
();

    localparam logic [31:0] SEED = 32'h526542b9;

    logic                  clk;
    logic                  rst_n;
    logic                  enable;
    logic [NUM_PORTS-1:0]  in_valid;
    logic [NUM_PORTS-1:0]  in_last;
    data_t [NUM_PORTS-1:0] in_data;
    logic [NUM_PORTS-1:0]  out_valid;
    logic [NUM_PORTS-1:0]  out_last;
    data_t [NUM_PORTS-1:0] out_data;
    logic [NUM_PORTS-1:0]  out_ready;
    logic                  status_clear;
    logic [NUM_PORTS-1:0]  drop;

    // Expected words per port
    data_t       exp_data [NUM_PORTS][$];
    logic        exp_last [NUM_PORTS][$];
    logic        stalled  [NUM_PORTS];
    data_t       held_data [NUM_PORTS];
    logic        held_last [NUM_PORTS];
    logic        prev_in_valid [NUM_PORTS];
    logic        prev_in_last  [NUM_PORTS];
    data_t       prev_in_data  [NUM_PORTS];
    logic [31:0] data_state;
    logic [31:0] ready_state;
    logic        rand_ready;
    logic [NUM_PORTS-1:0] ready_level;
    int          errors;
    int          checks;

    egress_qs u_egress_qs (
        .clk, .i_rst_n (rst_n), .i_enable (enable),
        .i_in_valid (in_valid), .i_in_last (in_last), .i_in_data (in_data),
        .o_out_valid (out_valid), .o_out_last (out_last), .o_out_data (out_data),
        .i_out_ready (out_ready), .i_status_clear (status_clear), .o_drop (drop)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_random();
        data_state = xorshift32(data_state);
        return data_state;
    endfunction

    function automatic bit drained();
        return exp_data[0].size() == 0 && exp_data[1].size() == 0 && out_valid == '0;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic end_run();
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    endtask

    // Drives one packet on each port with a nonzero length
    task automatic send_pair(input int len0, input int len1, input bit keep0, input bit keep1);
        int    lens [NUM_PORTS];
        bit    keep [NUM_PORTS];
        int    n;
        data_t w;
        lens[0] = len0;
        lens[1] = len1;
        keep[0] = keep0;
        keep[1] = keep1;
        n = (len0 > len1) ? len0 : len1;
        for (int k = 0; k < n; k++) begin
            @(posedge clk);
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (k < lens[p]) begin
                    w = next_random();
                    in_valid[p] <= 1'b1;
                    in_last[p]  <= (k == lens[p] - 1);
                    in_data[p]  <= w;
                    if (keep[p]) begin
                        exp_data[p].push_back(w);
                        exp_last[p].push_back(k == lens[p] - 1);
                    end
                end else begin
                    in_valid[p] <= 1'b0;
                    in_last[p]  <= 1'b0;
                end
            end
        end
        @(posedge clk);
        in_valid <= '0;
        in_last  <= '0;
    endtask

    task automatic wait_drain(input int limit);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!drained() && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (!drained()) begin
            $display("ERROR: output did not drain within %0d cycles", limit);
            errors++;
            end_run();
        end
    endtask

    task automatic wait_drop(input int p, input logic level, input int limit);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (drop[p] !== level && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (drop[p] !== level) begin
            $display("ERROR: o_drop[%0d] did not reach %0b within %0d cycles", p, level, limit);
            errors++;
            end_run();
        end
    endtask

    task automatic pulse_clear();
        @(posedge clk);
        status_clear <= 1'b1;
        @(posedge clk);
        status_clear <= 1'b0;
    endtask

    // --------------------------------------------------
    // Output monitor and ready driver
    // --------------------------------------------------
    always @(posedge clk) begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (rst_n && enable) begin
                if (stalled[p]) begin
                    check_value($sformatf("o_out_valid[%0d]", p), out_valid[p], 1'b1);
                    check_value($sformatf("o_out_data[%0d]", p), out_data[p], held_data[p]);
                    check_value($sformatf("o_out_last[%0d]", p), out_last[p], held_last[p]);
                end
                if (out_valid[p] && out_ready[p]) begin
                    if (exp_data[p].size() == 0) begin
                        $display("ERROR: port %0d sent a word that was never queued", p);
                        errors++;
                    end else begin
                        check_value($sformatf("o_out_data[%0d]", p), out_data[p],
                                    exp_data[p].pop_front());
                        check_value($sformatf("o_out_last[%0d]", p), out_last[p],
                                    exp_last[p].pop_front());
                    end
                end
                stalled[p]   = out_valid[p] && !out_ready[p];
                held_data[p] = out_data[p];
                held_last[p] = out_last[p];
            end else begin
                stalled[p] = 1'b0;
            end
            // Bypass output is the input of the previous cycle
            if (rst_n && !enable) begin
                check_value($sformatf("o_out_valid[%0d]", p), out_valid[p], prev_in_valid[p]);
                if (prev_in_valid[p]) begin
                    check_value($sformatf("o_out_data[%0d]", p), out_data[p], prev_in_data[p]);
                    check_value($sformatf("o_out_last[%0d]", p), out_last[p], prev_in_last[p]);
                end
            end
            prev_in_valid[p] = in_valid[p];
            prev_in_last[p]  = in_last[p];
            prev_in_data[p]  = in_data[p];
        end
    end

    always @(posedge clk) begin
        if (rand_ready) begin
            ready_state = xorshift32(ready_state);
            out_ready <= ready_state[NUM_PORTS-1:0];
        end else begin
            out_ready <= ready_level;
        end
    end

    // --------------------------------------------------
    // Tests
    // --------------------------------------------------
    task automatic test_queue_order();
        send_pair(1, 0, 1'b1, 1'b0);
        send_pair(5, 0, 1'b1, 1'b0);
        send_pair(16, 0, 1'b1, 1'b0);
        wait_drain(400);
        check_value("o_drop", drop, '0);
    endtask

    task automatic test_both_ports();
        send_pair(6, 6, 1'b1, 1'b1);
        send_pair(16, 2, 1'b1, 1'b1);
        send_pair(3, 11, 1'b1, 1'b1);
        wait_drain(600);
    endtask

    task automatic test_back_pressure();
        int len0;
        int len1;
        rand_ready = 1'b1;
        for (int i = 0; i < 6; i++) begin
            len0 = (next_random() % 16) + 1;
            len1 = (next_random() % 16) + 1;
            send_pair(len0, len1, 1'b1, 1'b1);
        end
        wait_drain(3000);
        rand_ready = 1'b0;
    endtask

    task automatic test_drops();
        send_pair(17, 0, 1'b0, 1'b0);
        wait_drop(0, 1'b1, 20);
        check_value("o_drop[1]", drop[1], 1'b0);
        pulse_clear();
        wait_drop(0, 1'b0, 5);
        // Stall port 0 so every slot stays in use
        ready_level[0] = 1'b0;
        for (int i = 0; i < NUM_SLOTS; i++) begin
            send_pair(3 + i, 0, 1'b1, 1'b0);
        end
        send_pair(5, 0, 1'b0, 1'b0);
        wait_drop(0, 1'b1, 20);
        ready_level[0] = 1'b1;
        wait_drain(1000);
        pulse_clear();
        wait_drop(0, 1'b0, 5);
    endtask

    task automatic test_bypass();
        rand_ready = 1'b1;
        @(posedge clk);
        enable <= 1'b0;
        send_pair(7, 3, 1'b0, 1'b0);
        send_pair(2, 9, 1'b0, 1'b0);
        repeat (2) @(posedge clk);
        @(negedge clk);
        rand_ready = 1'b0;
    endtask

    initial begin
        rst_n        = 1'b0;
        enable       = 1'b1;
        in_valid     = '0;
        in_last      = '0;
        in_data      = '0;
        out_ready    = '1;
        status_clear = 1'b0;
        ready_level  = '1;
        rand_ready   = 1'b0;
        data_state   = SEED;
        ready_state  = SEED;
        errors       = 0;
        checks       = 0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        test_queue_order();
        test_both_ports();
        test_back_pressure();
        test_drops();
        test_bypass();
        end_run();
    end

endmodule

// ==== egress_qs.f ====
design/egress_qs_pkg.sv
design/buf_rd_if.sv
design/buf_mem.sv
design/buf_rd_arbiter.sv
design/pkt_writer.sv
design/desc_fifo.sv
design/pkt_reader.sv
design/egress_port.sv
design/egress_qs.sv
tests/tb_egress_qs.sv
